//--- design/l2_wb_settings.svh
////////////////////////////////////////////////////////////////////////////
// Size settings for the L2 write buffer
// Included by the package and by every module that sizes ports from them
////////////////////////////////////////////////////////////////////////////

`ifndef L2_WB_SETTINGS_SVH
`define L2_WB_SETTINGS_SVH

// One data word per slot
`define WB_DATA_W 32

// Full word address tag
`define WB_TAG_W 30

// Low tag bits selecting a word within a line
// The line tag is the remaining upper bits
`define WB_WORD_IDX 4

// Slot count, must be a power of two
`define WB_DEPTH 16

`endif

//--- design/l2_wb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types for the L2 write buffer
// Slot index type and the drain FSM state encoding
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "l2_wb_settings.svh"

package l2_wb_pkg;

	// Bits needed to address one slot
	localparam int SLOT_W = $clog2(`WB_DEPTH);

	typedef logic [SLOT_W-1:0] slot_t;

	// Drain FSM toward memory
	typedef enum logic [1:0]
	{
		WB_IDLE,
		WB_FETCH,
		WB_SEND
	} drain_state_e;

endpackage

`default_nettype wire

//--- design/wb_tag_cam.sv
////////////////////////////////////////////////////////////////////////////
// Tag CAM of the L2 write buffer
// Holds per-slot tags and valid bits, finds merge targets for stores
// and answers line lookups from the L2 fill path
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "l2_wb_settings.svh"

module wb_tag_cam (
	input  wire                                 clk_l2,
	input  wire                                 rst_n,
	input  wire                                 push,
	input  wire                                 merge,
	input  wire                                 pop,
	input  wire                                 busy,
	input  wire                                 fetch,
	input  wire  l2_wb_pkg::slot_t              w_slot,
	input  wire  l2_wb_pkg::slot_t              r_slot,
	input  wire  [`WB_TAG_W-1:0]                store_tag,
	input  wire  [`WB_TAG_W-`WB_WORD_IDX-1:0]   read_line_tag,
	output logic                                write_hit,
	output l2_wb_pkg::slot_t                    hit_slot,
	output logic                                line_hit,
	output logic [`WB_TAG_W-1:0]                mem_tag
);

	import l2_wb_pkg::*;

	localparam int LINE_W = `WB_TAG_W - `WB_WORD_IDX;

	logic [`WB_TAG_W-1:0] tag_mem [`WB_DEPTH];
	logic [`WB_DEPTH-1:0] valid;
	logic [`WB_DEPTH-1:0] merge_match;
	logic [`WB_DEPTH-1:0] line_match;

	// Set on push, cleared when the head is popped
	always_ff @(posedge clk_l2 or negedge rst_n)
	begin
		if (!rst_n)
			valid <= '0;
		else
		begin
			if (push)
				valid[w_slot] <= 1'b1;
			if (pop)
				valid[r_slot] <= 1'b0;
		end
	end

	// Only a push writes a tag
	always_ff @(posedge clk_l2)
	begin
		if (push)
			tag_mem[w_slot] <= store_tag;
	end

	// Head tag held for the memory write
	always_ff @(posedge clk_l2 or negedge rst_n)
	begin
		if (!rst_n)
			mem_tag <= '0;
		else if (fetch)
			mem_tag <= tag_mem[r_slot];
	end

	////////////////////////////////////////////////////////////////////////////
	// Parallel search
	////////////////////////////////////////////////////////////////////////////

	// Head slot is off limits for merges once it is in flight
	always_comb
	begin
		for (int i = 0; i < `WB_DEPTH; i++)
		begin
			merge_match[i] = valid[i] && (tag_mem[i] == store_tag)
				&& !(busy && (slot_t'(i) == r_slot));
			line_match[i] = valid[i] && (tag_mem[i][`WB_TAG_W-1 -: LINE_W] == read_line_tag);
		end
	end

	always_comb
	begin
		hit_slot = '0;
		for (int i = 0; i < `WB_DEPTH; i++)
		begin
			if (merge_match[i])
				hit_slot = slot_t'(i);
		end
	end

	assign write_hit = |merge_match;
	assign line_hit  = |line_match;

	// Pushes never duplicate a mergeable tag, so a hit is unique
	a_unique_hit: assert property (@(posedge clk_l2) disable iff (!rst_n)
		$onehot0(merge_match));

endmodule

`default_nettype wire

//--- design/wb_slot_queue.sv
////////////////////////////////////////////////////////////////////////////
// Slot queue of the L2 write buffer
// Data RAM with FIFO pointers; merges overwrite a pending slot in place
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "l2_wb_settings.svh"

module wb_slot_queue (
	input  wire                         clk_l2,
	input  wire                         rst_n,
	input  wire                         push,
	input  wire                         merge,
	input  wire  l2_wb_pkg::slot_t      hit_slot,
	input  wire  [`WB_DATA_W-1:0]       store_data,
	input  wire                         pop,
	input  wire                         fetch,
	output l2_wb_pkg::slot_t            w_slot,
	output l2_wb_pkg::slot_t            r_slot,
	output logic                        full,
	output logic                        empty,
	output logic [`WB_DATA_W-1:0]       mem_data
);

	import l2_wb_pkg::*;

	logic [`WB_DATA_W-1:0] data_mem [`WB_DEPTH];

	// One extra bit tells full from empty
	logic [SLOT_W:0] w_ptr;
	logic [SLOT_W:0] r_ptr;

	always_ff @(posedge clk_l2 or negedge rst_n)
	begin
		if (!rst_n)
			w_ptr <= '0;
		else if (push)
			w_ptr <= w_ptr + 1'b1;
	end

	always_ff @(posedge clk_l2 or negedge rst_n)
	begin
		if (!rst_n)
			r_ptr <= '0;
		else if (pop)
			r_ptr <= r_ptr + 1'b1;
	end

	assign w_slot = w_ptr[SLOT_W-1:0];
	assign r_slot = r_ptr[SLOT_W-1:0];
	assign empty  = (w_ptr == r_ptr);
	assign full   = (w_slot == r_slot) && (w_ptr[SLOT_W] != r_ptr[SLOT_W]);

	// New word at the tail, or overwrite at the matching slot
	always_ff @(posedge clk_l2)
	begin
		if (push)
			data_mem[w_slot] <= store_data;
		else if (merge)
			data_mem[hit_slot] <= store_data;
	end

	// Head word held stable while memory takes it
	always_ff @(posedge clk_l2 or negedge rst_n)
	begin
		if (!rst_n)
			mem_data <= '0;
		else if (fetch)
			mem_data <= data_mem[r_slot];
	end

	a_no_push_full: assert property (@(posedge clk_l2) disable iff (!rst_n)
		!(push && full));

	a_no_pop_empty: assert property (@(posedge clk_l2) disable iff (!rst_n)
		!(pop && empty));

endmodule

`default_nettype wire

//--- design/wb_drain_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Drain controller of the L2 write buffer
// Sorts stores into merge, push or overflow, and runs the FSM that
// fetches the head entry and holds mem_req until memory acknowledges
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module wb_drain_ctrl (
	input  wire     clk_l2,
	input  wire     rst_n,
	input  wire     store,
	input  wire     write_hit,
	input  wire     full,
	input  wire     empty,
	input  wire     mem_ack,
	output logic    push,
	output logic    merge,
	output logic    pop,
	output logic    fetch,
	output logic    busy,
	output logic    mem_req,
	output logic    overflow
);

	import l2_wb_pkg::*;

	drain_state_e state;
	drain_state_e state_nx;

	////////////////////////////////////////////////////////////////////////////
	// Store classification
	////////////////////////////////////////////////////////////////////////////

	// Merge wins even when full
	assign merge    = store && write_hit;
	assign push     = store && !write_hit && !full;
	assign overflow = store && !write_hit && full;

	////////////////////////////////////////////////////////////////////////////
	// Drain FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_l2 or negedge rst_n)
	begin
		if (!rst_n)
			state <= WB_IDLE;
		else
			state <= state_nx;
	end

	always_comb
	begin
		state_nx = state;
		case (state)
			WB_IDLE:
			begin
				if (!empty)
					state_nx = WB_FETCH;
			end
			WB_FETCH:
				state_nx = WB_SEND;
			WB_SEND:
			begin
				if (mem_ack)
					state_nx = WB_IDLE;
			end
			default:
				state_nx = WB_IDLE;
		endcase
	end

	// Head is read out on the edge that enters WB_FETCH
	assign fetch   = (state == WB_IDLE) && !empty;
	assign pop     = (state == WB_SEND) && mem_ack;
	assign mem_req = (state != WB_IDLE);

	// Covers the fetch cycle too, so a merge cannot race the head read
	assign busy = fetch || mem_req;

	a_req_until_ack: assert property (@(posedge clk_l2) disable iff (!rst_n)
		(mem_req && !mem_ack) |=> mem_req);

endmodule

`default_nettype wire

//--- design/l2_write_buffer.sv
////////////////////////////////////////////////////////////////////////////
// L2 write buffer top level
// Queues dirty words from the L2 and drains them to memory in order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "l2_wb_settings.svh"

module l2_write_buffer (
	input  wire                                 clk_l2,
	input  wire                                 rst_n,
	input  wire                                 store,
	input  wire  [`WB_TAG_W-1:0]                store_tag,
	input  wire  [`WB_DATA_W-1:0]               store_data,
	input  wire  [`WB_TAG_W-`WB_WORD_IDX-1:0]   read_line_tag,
	input  wire                                 mem_ack,
	output logic                                mem_req,
	output logic [`WB_TAG_W-1:0]                mem_tag,
	output logic [`WB_DATA_W-1:0]               mem_data,
	output logic                                full,
	output logic                                empty,
	output logic                                overflow,
	output logic                                line_hit
);

	import l2_wb_pkg::*;

	slot_t w_slot;
	slot_t r_slot;
	slot_t hit_slot;
	logic  write_hit;
	logic  push;
	logic  merge;
	logic  pop;
	logic  fetch;
	logic  busy;

	wb_slot_queue i_wb_slot_queue (
		.clk_l2     (clk_l2),
		.rst_n      (rst_n),
		.push       (push),
		.merge      (merge),
		.hit_slot   (hit_slot),
		.store_data (store_data),
		.pop        (pop),
		.fetch      (fetch),
		.w_slot     (w_slot),
		.r_slot     (r_slot),
		.full       (full),
		.empty      (empty),
		.mem_data   (mem_data)
	);

	wb_tag_cam i_wb_tag_cam (
		.clk_l2        (clk_l2),
		.rst_n         (rst_n),
		.push          (push),
		.merge         (merge),
		.pop           (pop),
		.busy          (busy),
		.fetch         (fetch),
		.w_slot        (w_slot),
		.r_slot        (r_slot),
		.store_tag     (store_tag),
		.read_line_tag (read_line_tag),
		.write_hit     (write_hit),
		.hit_slot      (hit_slot),
		.line_hit      (line_hit),
		.mem_tag       (mem_tag)
	);

	wb_drain_ctrl i_wb_drain_ctrl (
		.clk_l2    (clk_l2),
		.rst_n     (rst_n),
		.store     (store),
		.write_hit (write_hit),
		.full      (full),
		.empty     (empty),
		.mem_ack   (mem_ack),
		.push      (push),
		.merge     (merge),
		.pop       (pop),
		.fetch     (fetch),
		.busy      (busy),
		.mem_req   (mem_req),
		.overflow  (overflow)
	);

endmodule

`default_nettype wire

//--- test/tb_l2_write_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the L2 write buffer
// Runs a table of stores, lookups and drain steps against a reference
// queue, with a memory responder that checks every write to memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "l2_wb_settings.svh"

module tb_l2_write_buffer;

	localparam int LINE_W = `WB_TAG_W - `WB_WORD_IDX;

	localparam logic [2:0] ACT_STORE    = 3'd0;
	localparam logic [2:0] ACT_LOOKUP   = 3'd1;
	localparam logic [2:0] ACT_ACK_ON   = 3'd2;
	localparam logic [2:0] ACT_ACK_OFF  = 3'd3;
	localparam logic [2:0] ACT_DRAIN    = 3'd4;
	localparam logic [2:0] ACT_WAIT_REQ = 3'd5;

	// Expected flag values, DC is not checked
	localparam logic [1:0] LO = 2'd0;
	localparam logic [1:0] HI = 2'd1;
	localparam logic [1:0] DC = 2'd2;

	typedef struct packed
	{
		logic [2:0]            act;
		logic [3:0]            test;
		logic [`WB_TAG_W-1:0]  tag;
		logic [`WB_DATA_W-1:0] data;
		logic [1:0]            e_full;
		logic [1:0]            e_empty;
		logic [1:0]            e_ovf;
		logic [1:0]            e_line;
		logic [1:0]            e_req;
	} step_t;

	logic                  clk_l2;
	logic                  rst_n;
	logic                  store;
	logic [`WB_TAG_W-1:0]  store_tag;
	logic [`WB_DATA_W-1:0] store_data;
	logic [LINE_W-1:0]     read_line_tag;
	logic                  mem_ack;
	wire                   mem_req;
	wire [`WB_TAG_W-1:0]   mem_tag;
	wire [`WB_DATA_W-1:0]  mem_data;
	wire                   full;
	wire                   empty;
	wire                   overflow;
	wire                   line_hit;

	step_t                 steps [$];
	logic [`WB_TAG_W-1:0]  model_tag [$];
	logic [`WB_DATA_W-1:0] model_data [$];
	string                 test_name [1:6];
	logic [31:0]           seed;
	logic                  ack_en;
	int                    req_cycles;
	int                    errors;
	int                    tests_failed;
	int                    writes;

	l2_write_buffer i_l2_write_buffer (
		.clk_l2        (clk_l2),
		.rst_n         (rst_n),
		.store         (store),
		.store_tag     (store_tag),
		.store_data    (store_data),
		.read_line_tag (read_line_tag),
		.mem_ack       (mem_ack),
		.mem_req       (mem_req),
		.mem_tag       (mem_tag),
		.mem_data      (mem_data),
		.full          (full),
		.empty         (empty),
		.overflow      (overflow),
		.line_hit      (line_hit)
	);

	initial
		clk_l2 = 1'b0;

	always #4 clk_l2 = ~clk_l2;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	task automatic add_step(input logic [2:0] act, input logic [3:0] test,
		input logic [`WB_TAG_W-1:0] tag, input logic [1:0] e_full,
		input logic [1:0] e_empty, input logic [1:0] e_ovf,
		input logic [1:0] e_line, input logic [1:0] e_req);
		step_t s;
		s = {act, test, tag, lcg_next(), e_full, e_empty, e_ovf, e_line, e_req};
		steps.push_back(s);
	endtask

	task automatic expect_flag(input string name, input logic got, input logic [1:0] exp);
		if (exp != DC && got !== exp[0])
		begin
			$display("ERR %s: got %h, expected %h", name, got, exp[0]);
			errors++;
		end
	endtask

	// Merge into a pending entry, else append unless the queue is full
	task automatic model_store(input logic [`WB_TAG_W-1:0] tag,
		input logic [`WB_DATA_W-1:0] data);
		int hit;
		hit = -1;
		// The drain claims the head as soon as anything is pending
		for (int i = 1; i < model_tag.size(); i++)
		begin
			if (model_tag[i] == tag)
				hit = i;
		end
		if (hit >= 0)
			model_data[hit] = data;
		else if (model_tag.size() < `WB_DEPTH)
		begin
			model_tag.push_back(tag);
			model_data.push_back(data);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Clock step with memory responder
	////////////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_l2);
		// A store and a pop on the same edge: the store sees the queue first
		if (store)
			model_store(store_tag, store_data);
		if (mem_ack && model_tag.size() != 0)
		begin
			void'(model_tag.pop_front());
			void'(model_data.pop_front());
		end
		#1;
		if (mem_ack)
		begin
			mem_ack = 1'b0;
			req_cycles = 0;
			expect_flag("mem_req", mem_req, LO);
		end
		else if (mem_req)
		begin
			req_cycles++;
			// Acknowledge one cycle after the request was first seen
			if (ack_en && req_cycles >= 2)
			begin
				if (model_tag.size() == 0)
				begin
					$display("Memory write seen while nothing is pending");
					errors++;
				end
				else
				begin
					if (mem_tag !== model_tag[0])
					begin
						$display("ERR mem_tag: got %h, expected %h", mem_tag, model_tag[0]);
						errors++;
					end
					if (mem_data !== model_data[0])
					begin
						$display("ERR mem_data: got %h, expected %h", mem_data, model_data[0]);
						errors++;
					end
				end
				writes++;
				mem_ack = 1'b1;
			end
		end
	endtask

	task automatic drain_all();
		int n;
		n = 0;
		while ((model_tag.size() != 0 || !empty || mem_req || mem_ack) && n < 200)
		begin
			tick();
			n++;
		end
		if (model_tag.size() != 0 || !empty || mem_req)
		begin
			$display("Buffer did not drain within 200 cycles");
			errors++;
		end
	endtask

	task automatic wait_req();
		int n;
		n = 0;
		while (!mem_req && n < 20)
		begin
			tick();
			n++;
		end
		if (!mem_req)
		begin
			$display("mem_req did not rise within 20 cycles");
			errors++;
		end
	endtask

	task automatic apply_step(input step_t s);
		case (s.act)
			ACT_STORE:
			begin
				store = 1'b1;
				store_tag = s.tag;
				store_data = s.data;
				// Overflow only shows during the store cycle
				#3;
				expect_flag("overflow", overflow, s.e_ovf);
				tick();
				store = 1'b0;
			end
			ACT_LOOKUP:
			begin
				read_line_tag = s.tag[`WB_TAG_W-1 -: LINE_W];
				#1;
				expect_flag("line_hit", line_hit, s.e_line);
				tick();
			end
			ACT_ACK_ON:
			begin
				ack_en = 1'b1;
				tick();
			end
			ACT_ACK_OFF:
			begin
				ack_en = 1'b0;
				tick();
			end
			ACT_WAIT_REQ:
				wait_req();
			default:
				drain_all();
		endcase
		expect_flag("full", full, s.e_full);
		expect_flag("empty", empty, s.e_empty);
		expect_flag("mem_req", mem_req, s.e_req);
		if (s.act != ACT_STORE)
			expect_flag("overflow", overflow, s.e_ovf);
	endtask

	task automatic report_test(input int num, input int err_start);
		if (errors == err_start)
			$display("test %0d %s: ok", num, test_name[num]);
		else
		begin
			$display("test %0d %s: %0d errors", num, test_name[num], errors - err_start);
			tests_failed++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Step table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		test_name[1] = "reset state";
		test_name[2] = "drain order";
		test_name[3] = "merge in place";
		test_name[4] = "line lookup";
		test_name[5] = "full and overflow";
		test_name[6] = "store to head in flight";

		add_step(ACT_ACK_OFF, 1, '0, LO, HI, LO, DC, LO);

		add_step(ACT_ACK_ON, 2, '0, DC, DC, DC, DC, DC);
		for (int i = 0; i < 4; i++)
			add_step(ACT_STORE, 2, 30'h0100_0000 + 30'(i * 8), DC, DC, LO, DC, DC);
		add_step(ACT_DRAIN, 2, '0, LO, HI, LO, DC, LO);

		add_step(ACT_ACK_OFF, 3, '0, LO, HI, LO, DC, LO);
		add_step(ACT_STORE, 3, 30'h0110_0000, LO, LO, LO, DC, DC);
		add_step(ACT_STORE, 3, 30'h0110_0040, LO, LO, LO, DC, DC);
		add_step(ACT_STORE, 3, 30'h0110_0040, LO, LO, LO, DC, DC);
		add_step(ACT_ACK_ON, 3, '0, DC, DC, DC, DC, DC);
		add_step(ACT_DRAIN, 3, '0, LO, HI, LO, DC, LO);

		// Two pending lines, one of them the head
		add_step(ACT_ACK_OFF, 4, '0, LO, HI, LO, DC, LO);
		add_step(ACT_STORE, 4, 30'h0200_0013, LO, LO, LO, DC, DC);
		add_step(ACT_STORE, 4, 30'h0240_0020, LO, LO, LO, DC, DC);
		add_step(ACT_LOOKUP, 4, 30'h0200_0017, DC, DC, LO, HI, DC);
		add_step(ACT_LOOKUP, 4, 30'h0240_002c, DC, DC, LO, HI, DC);
		add_step(ACT_LOOKUP, 4, 30'h0300_0000, DC, DC, LO, LO, DC);
		add_step(ACT_ACK_ON, 4, '0, DC, DC, DC, DC, DC);
		add_step(ACT_DRAIN, 4, '0, LO, HI, LO, DC, LO);
		add_step(ACT_LOOKUP, 4, 30'h0200_0013, LO, HI, LO, LO, LO);

		add_step(ACT_ACK_OFF, 5, '0, LO, HI, LO, DC, LO);
		for (int i = 0; i < `WB_DEPTH; i++)
			add_step(ACT_STORE, 5, 30'h0500_0000 + 30'(i * 4),
				(i == `WB_DEPTH - 1) ? HI : LO, LO, LO, DC, DC);
		add_step(ACT_STORE, 5, 30'h0600_0000, HI, LO, HI, DC, DC);
		add_step(ACT_STORE, 5, 30'h0500_0014, HI, LO, LO, DC, DC);
		add_step(ACT_ACK_ON, 5, '0, DC, DC, DC, DC, DC);
		add_step(ACT_DRAIN, 5, '0, LO, HI, LO, DC, LO);

		add_step(ACT_ACK_OFF, 6, '0, LO, HI, LO, DC, LO);
		add_step(ACT_STORE, 6, 30'h0700_0008, LO, LO, LO, DC, DC);
		add_step(ACT_WAIT_REQ, 6, '0, LO, LO, LO, DC, HI);
		add_step(ACT_STORE, 6, 30'h0700_0008, LO, LO, LO, DC, HI);
		add_step(ACT_ACK_ON, 6, '0, DC, DC, DC, DC, DC);
		add_step(ACT_DRAIN, 6, '0, LO, HI, LO, DC, LO);
	endtask

	initial
	begin
		int cur;
		int err_start;
		seed = 32'h3680_c3ac;
		rst_n = 1'b0;
		store = 1'b0;
		store_tag = '0;
		store_data = '0;
		read_line_tag = '0;
		mem_ack = 1'b0;
		ack_en = 1'b0;
		req_cycles = 0;
		errors = 0;
		tests_failed = 0;
		writes = 0;
		build_table();
		repeat (5) @(posedge clk_l2);
		#1;
		rst_n = 1'b1;
		cur = steps[0].test;
		err_start = 0;
		for (int k = 0; k < steps.size(); k++)
		begin
			if (steps[k].test != cur)
			begin
				report_test(cur, err_start);
				cur = steps[k].test;
				err_start = errors;
			end
			apply_step(steps[k]);
		end
		report_test(cur, err_start);
		$display("%0d tests, %0d failed, %0d errors, %0d memory writes",
			6, tests_failed, errors, writes);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/l2_wb_pkg.sv
design/wb_tag_cam.sv
design/wb_slot_queue.sv
design/wb_drain_ctrl.sv
design/l2_write_buffer.sv
test/tb_l2_write_buffer.sv

//--- Bender.yml
package:
  name: l2_write_buffer

sources:
  - include_dirs:
      - design
    files:
      - design/l2_wb_pkg.sv
      - design/wb_tag_cam.sv
      - design/wb_slot_queue.sv
      - design/wb_drain_ctrl.sv
      - design/l2_write_buffer.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/tb_l2_write_buffer.sv
